//--- list.f
+incdir+include
verilog/cache_pkg.sv
verilog/tag_lookup.sv
verilog/lru_tracker.sv
verilog/cache_controller.sv
verilog/backing_memory.sv
verilog/response_unit.sv
verilog/l1_cache_top.sv
tests/l1_cache_tb.sv

//--- tests/l1_cache_tb.sv
`default_nettype none

`include "cache_macros.svh"

module l1_cache_tb;
    timeunit 1ns;
    timeprecision 100ps;

    import cache_pkg::*;

    localparam int CLK_PERIOD         = 4;
    localparam int RESET_CYCLES       = 5;
    localparam int RANDOM_OPS         = 200;
    localparam int MAX_REQUESTS       = 300;
    localparam int CYCLES_PER_REQUEST = 20;

    logic      clk_in;
    logic      reset;
    logic      req_valid;
    cpu_req_t  req;
    logic      resp_valid;
    cpu_resp_t resp;

    // Reference model: written bytes and per-set tags, most recent first.
    logic [7:0]             mem_model [logic [`ADDR_WIDTH-1:0]];
    logic [`TAG_BITS-1:0]   recency [`CACHE_SETS][`CACHE_WAYS];
    int                     used [`CACHE_SETS];
    logic [`ADDR_WIDTH-1:0] written_addrs [$];

    logic                   pending;
    logic [`ADDR_WIDTH-1:0] cur_addr;
    logic [7:0]             exp_rdata;
    logic                   exp_hit;

    l1_cache_top u_dut (
        .clk_in     (clk_in),
        .reset      (reset),
        .req_valid  (req_valid),
        .req        (req),
        .resp_valid (resp_valid),
        .resp       (resp)
    );

    initial begin
        clk_in = 1'b0;
        forever #(CLK_PERIOD / 2) clk_in = ~clk_in;
    end

    task automatic stop_with_failure(input string reason);
        $display("%s", reason);
        $display("Simulation failed");
        $fatal(1);
    endtask

    // ----------------------------------------------------------------------
    // Checks on the response port.
    // ----------------------------------------------------------------------
    response_matches_model: assert property (
        @(posedge clk_in) disable iff (reset)
        resp_valid |-> (resp.rdata === exp_rdata) && (resp.hit === exp_hit)
    ) else stop_with_failure($sformatf(
        "FAIL %0t: access to %h returned %h hit %b, expected %h hit %b", $time,
        $sampled(cur_addr), $sampled(resp.rdata), $sampled(resp.hit),
        $sampled(exp_rdata), $sampled(exp_hit)));

    response_only_when_pending: assert property (
        @(posedge clk_in) disable iff (reset)
        resp_valid |-> pending
    ) else stop_with_failure($sformatf("FAIL %0t: resp_valid with no request outstanding", $time));

    response_is_one_cycle: assert property (
        @(posedge clk_in) disable iff (reset)
        resp_valid |=> !resp_valid
    ) else stop_with_failure($sformatf("FAIL %0t: resp_valid held longer than one cycle", $time));

    // LRU rule of the model; returns whether the tag was present.
    function automatic logic update_recency(input logic [`INDEX_BITS-1:0] set,
                                            input logic [`TAG_BITS-1:0] tag);
        int pos;
        pos = -1;
        for (int i = 0; i < used[set]; i++) begin
            if (recency[set][i] == tag) begin
                pos = i;
            end
        end
        if (pos < 0 && used[set] < `CACHE_WAYS) begin
            used[set] = used[set] + 1;
        end
        for (int i = (pos < 0) ? used[set] - 1 : pos; i > 0; i--) begin
            recency[set][i] = recency[set][i-1];
        end
        recency[set][0] = tag;
        return pos >= 0;
    endfunction

    // One request, then wait for its response.
    task automatic access(input logic is_store, input logic [`ADDR_WIDTH-1:0] addr,
                          input logic [7:0] wdata);
        addr_fields_t fields;
        fields   = addr_fields_t'(addr);
        exp_hit  = update_recency(fields.index, fields.tag);
        cur_addr = addr;
        if (is_store) begin
            mem_model[addr] = wdata;
            exp_rdata       = wdata;
        end else begin
            exp_rdata = mem_model[addr];
        end
        @(posedge clk_in);
        req_valid <= 1'b1;
        req       <= '{write: is_store, addr: addr, wdata: wdata};
        pending    = 1'b1;
        @(posedge clk_in);
        req_valid <= 1'b0;
        do @(posedge clk_in); while (resp_valid !== 1'b1);
        pending = 1'b0;
    endtask

    initial begin
        #(CLK_PERIOD * (RESET_CYCLES + MAX_REQUESTS * CYCLES_PER_REQUEST));
        stop_with_failure("Timeout: the cache stopped answering requests");
    end

    initial begin
        logic [`ADDR_WIDTH-1:0] addr;
        addr_fields_t           fields;
        logic [31:0]            r;
        void'($urandom(91061));
        reset     = 1'b1;
        req_valid = 1'b0;
        req       = '0;
        pending   = 1'b0;
        for (int s = 0; s < `CACHE_SETS; s++) begin
            used[s] = 0;
        end
        repeat (RESET_CYCLES) @(posedge clk_in);
        reset <= 1'b0;
        // Idle a while so a stray resp_valid would be caught.
        repeat (10) @(posedge clk_in);

        // Store then load the same byte.
        access(1'b1, 12'h123, 8'h5a);
        access(1'b0, 12'h123, 8'h00);

        // Fill one line byte by byte, then read it back.
        for (int i = 0; i < `LINE_BYTES; i++) begin
            access(1'b1, 12'h040 + i, 8'ha0 ^ 8'(i * 7));
        end
        for (int i = 0; i < `LINE_BYTES; i++) begin
            access(1'b0, 12'h040 + i, 8'h00);
        end

        // Set 5 with tags 1 to 5; tag 5 evicts tag 2.
        for (int t = 1; t <= 4; t++) begin
            access(1'b1, {4'(t), 4'h5, 4'h3}, 8'h10 + 8'(t));
        end
        access(1'b0, 12'h153, 8'h00);
        access(1'b1, 12'h553, 8'h15);
        access(1'b0, 12'h153, 8'h00);
        access(1'b0, 12'h253, 8'h00);

        // Random mix over six tags in two sets.
        for (int n = 0; n < RANDOM_OPS; n++) begin
            r = $urandom;
            if (written_addrs.size() > 0 && r[0]) begin
                addr = written_addrs[$urandom_range(written_addrs.size() - 1, 0)];
                access(1'b0, addr, 8'h00);
            end else begin
                r             = $urandom_range(5, 0);
                fields.tag    = r[`TAG_BITS-1:0];
                r             = 8 + $urandom_range(1, 0);
                fields.index  = r[`INDEX_BITS-1:0];
                r             = $urandom_range(3, 0);
                fields.offset = r[`OFFSET_BITS-1:0];
                addr          = fields;
                r             = $urandom;
                written_addrs.push_back(addr);
                access(1'b1, addr, r[7:0]);
            end
        end

        @(posedge clk_in);
        $display("Simulation completed successfully");
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog/l1_cache_top.sv
`default_nettype none

`include "cache_macros.svh"

module l1_cache_top (
    input  logic                   clk_in,
    input  logic                   reset,
    input  logic                   req_valid,
    input  cache_pkg::cpu_req_t    req,
    output logic                   resp_valid,
    output cache_pkg::cpu_resp_t   resp
);
    import cache_pkg::*;

    logic                    mem_req_valid;
    mem_req_t                mem_req;
    logic                    fill_valid;
    line_t                   fill_line;
    logic                    done;
    line_t                   done_line;
    logic [`OFFSET_BITS-1:0] done_offset;
    logic                    done_hit;

    cache_controller u_cache_controller (
        .clk_in        (clk_in),
        .reset         (reset),
        .req_valid     (req_valid),
        .req           (req),
        .mem_req_valid (mem_req_valid),
        .mem_req       (mem_req),
        .fill_valid    (fill_valid),
        .fill_line     (fill_line),
        .done          (done),
        .done_line     (done_line),
        .done_offset   (done_offset),
        .done_hit      (done_hit)
    );

    backing_memory u_backing_memory (
        .clk_in        (clk_in),
        .reset         (reset),
        .mem_req_valid (mem_req_valid),
        .mem_req       (mem_req),
        .fill_valid    (fill_valid),
        .fill_line     (fill_line)
    );

    response_unit u_response_unit (
        .clk_in      (clk_in),
        .reset       (reset),
        .done        (done),
        .done_line   (done_line),
        .done_offset (done_offset),
        .done_hit    (done_hit),
        .resp_valid  (resp_valid),
        .resp        (resp)
    );

endmodule

`default_nettype wire

//--- verilog/response_unit.sv
`default_nettype none

`include "cache_macros.svh"

module response_unit (
    input  logic                    clk_in,
    input  logic                    reset,
    input  logic                    done,
    input  cache_pkg::line_t        done_line,
    input  logic [`OFFSET_BITS-1:0] done_offset,
    input  logic                    done_hit,
    output logic                    resp_valid,
    output cache_pkg::cpu_resp_t    resp
);

    // One cycle copy of done.
    always_ff @(posedge clk_in) begin
        if (reset) begin
            resp_valid <= 1'b0;
        end else begin
            resp_valid <= done;
        end
    end

    // Addressed byte and hit flag, held until the next completion.
    // For a store the line already carries the new byte.
    always_ff @(posedge clk_in) begin
        if (done) begin
            resp.rdata <= done_line[done_offset];
            resp.hit   <= done_hit;
        end
    end

endmodule

`default_nettype wire

//--- verilog/backing_memory.sv
`default_nettype none

`include "cache_macros.svh"

module backing_memory (
    input  logic                  clk_in,
    input  logic                  reset,
    input  logic                  mem_req_valid,
    input  cache_pkg::mem_req_t   mem_req,
    output logic                  fill_valid,
    output cache_pkg::line_t      fill_line
);

    logic [7:0]                          mem [1 << `ADDR_WIDTH];

    // Delay pipe for line reads.
    logic [`MEM_LATENCY-1:0]             pipe_valid;
    logic [`ADDR_WIDTH-`OFFSET_BITS-1:0] pipe_line [`MEM_LATENCY];
    logic [`ADDR_WIDTH-1:0]              fill_base;

    // Single byte writes.
    always_ff @(posedge clk_in) begin
        if (mem_req_valid && mem_req.write) begin
            mem[mem_req.addr] <= mem_req.wdata;
        end
    end

    always_ff @(posedge clk_in) begin
        if (reset) begin
            pipe_valid <= '0;
        end else begin
            pipe_valid <= {pipe_valid[`MEM_LATENCY-2:0], mem_req_valid && !mem_req.write};
        end
    end

    always_ff @(posedge clk_in) begin
        pipe_line[0] <= mem_req.addr[`ADDR_WIDTH-1:`OFFSET_BITS];
        for (int i = 1; i < `MEM_LATENCY; i++) begin
            pipe_line[i] <= pipe_line[i-1];
        end
    end

    // Aligned line at the end of the pipe.
    assign fill_base = {pipe_line[`MEM_LATENCY-1], {`OFFSET_BITS{1'b0}}};

    always_comb begin
        for (int b = 0; b < `LINE_BYTES; b++) begin
            fill_line[b] = mem[fill_base + b];
        end
    end

    assign fill_valid = pipe_valid[`MEM_LATENCY-1];

endmodule

`default_nettype wire

//--- verilog/cache_controller.sv
`default_nettype none

`include "cache_macros.svh"

module cache_controller (
    input  logic                    clk_in,
    input  logic                    reset,
    input  logic                    req_valid,
    input  cache_pkg::cpu_req_t     req,
    output logic                    mem_req_valid,
    output cache_pkg::mem_req_t     mem_req,
    input  logic                    fill_valid,
    input  cache_pkg::line_t        fill_line,
    output logic                    done,
    output cache_pkg::line_t        done_line,
    output logic [`OFFSET_BITS-1:0] done_offset,
    output logic                    done_hit
);
    import cache_pkg::*;

    typedef enum logic [1:0] {
        IDLE,
        LOOKUP,
        FILL,
        UPDATE
    } state_t;

    state_t                  state;
    cpu_req_t                req_q;
    addr_fields_t            req_fields;
    logic [`INDEX_BITS-1:0]  set_idx;
    logic                    missed;
    way_idx_t                way_q;
    lookup_t                 lookup;
    way_idx_t                victim;
    logic                    install;
    logic                    store_hit;

    // ------------------------------------------------------------------
    // Tag, valid and data arrays.
    // ------------------------------------------------------------------
    logic [`CACHE_WAYS-1:0][`TAG_BITS-1:0]   tag_arr [`CACHE_SETS];
    logic [`CACHE_SETS-1:0][`CACHE_WAYS-1:0] valid_arr;
    line_t                                   data_arr [`CACHE_SETS][`CACHE_WAYS];

    assign req_fields = addr_fields_t'(req_q.addr);
    assign set_idx    = req_fields.index;

    tag_lookup u_tag_lookup (
        .addr   (req_q.addr),
        .tags   (tag_arr[set_idx]),
        .valids (valid_arr[set_idx]),
        .result (lookup)
    );

    // The set under access is both touched and queried.
    lru_tracker u_lru_tracker (
        .clk_in    (clk_in),
        .reset     (reset),
        .touch     (done),
        .touch_set (set_idx),
        .touch_way (way_q),
        .query_set (set_idx),
        .victim    (victim)
    );

    // ------------------------------------------------------------------
    // Access sequence.
    // ------------------------------------------------------------------
    // A miss installs the line and goes back to LOOKUP, which then hits.
    always_ff @(posedge clk_in) begin
        if (reset) begin
            state  <= IDLE;
            missed <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    if (req_valid) begin
                        state  <= LOOKUP;
                        missed <= 1'b0;
                    end
                end
                LOOKUP: begin
                    if (lookup.hit) begin
                        state <= UPDATE;
                    end else begin
                        state  <= FILL;
                        missed <= 1'b1;
                    end
                end
                FILL: begin
                    if (fill_valid) begin
                        state <= LOOKUP;
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk_in) begin
        if (state == IDLE && req_valid) begin
            req_q <= req;
        end
        if (state == LOOKUP && lookup.hit) begin
            way_q <= lookup.way;
        end
    end

    assign install   = (state == FILL) && fill_valid;
    assign store_hit = (state == LOOKUP) && lookup.hit && req_q.write;

    always_ff @(posedge clk_in) begin
        if (reset) begin
            valid_arr <= '0;
        end else if (install) begin
            valid_arr[set_idx][victim] <= 1'b1;
        end
    end

    // Fill into the victim way; stores merge their byte on the hit.
    always_ff @(posedge clk_in) begin
        if (install) begin
            tag_arr[set_idx][victim]  <= lookup.fields.tag;
            data_arr[set_idx][victim] <= fill_line;
        end
        if (store_hit) begin
            data_arr[set_idx][lookup.way][lookup.fields.offset] <= req_q.wdata;
        end
    end

    // ------------------------------------------------------------------
    // Memory requests and completion.
    // ------------------------------------------------------------------
    // Line read on a miss, byte write-through in UPDATE.
    assign mem_req_valid = ((state == LOOKUP) && !lookup.hit)
                        || ((state == UPDATE) && req_q.write);
    assign mem_req = '{
        write: (state == UPDATE),
        addr:  req_q.addr,
        wdata: req_q.wdata
    };

    assign done        = (state == UPDATE);
    assign done_line   = data_arr[set_idx][way_q];
    assign done_offset = lookup.fields.offset;
    assign done_hit    = !missed;

    // The CPU holds off until the response of the previous request.
    no_request_while_busy: assert property (
        @(posedge clk_in) disable iff (reset)
        (state != IDLE) |-> !req_valid
    ) else $error("cache_controller: request issued before the previous response");

endmodule

`default_nettype wire

//--- verilog/lru_tracker.sv
`default_nettype none

`include "cache_macros.svh"

module lru_tracker (
    input  logic                    clk_in,
    input  logic                    reset,
    input  logic                    touch,
    input  logic [`INDEX_BITS-1:0]  touch_set,
    input  cache_pkg::way_idx_t     touch_way,
    input  logic [`INDEX_BITS-1:0]  query_set,
    output cache_pkg::way_idx_t     victim
);
    import cache_pkg::*;

    typedef way_idx_t [`CACHE_WAYS-1:0] order_t;

    // Entry 0 is the most recent way, the last entry the victim.
    order_t   order [`CACHE_SETS];
    order_t   cur_order;
    order_t   next_order;
    way_idx_t touch_pos;

    function automatic logic is_permutation(order_t list);
        logic [`CACHE_WAYS-1:0] seen;
        seen = '0;
        for (int i = 0; i < `CACHE_WAYS; i++) begin
            seen[list[i]] = 1'b1;
        end
        return &seen;
    endfunction

    // Move the touched way to the front and shift the ways ahead of it back.
    always_comb begin
        cur_order = order[touch_set];
        touch_pos = '0;
        for (int i = 0; i < `CACHE_WAYS; i++) begin
            if (cur_order[i] == touch_way) begin
                touch_pos = way_idx_t'(i);
            end
        end
        next_order    = cur_order;
        next_order[0] = touch_way;
        for (int i = 1; i < `CACHE_WAYS; i++) begin
            if (i <= touch_pos) begin
                next_order[i] = cur_order[i-1];
            end
        end
    end

    always_ff @(posedge clk_in) begin
        if (reset) begin
            for (int s = 0; s < `CACHE_SETS; s++) begin
                for (int i = 0; i < `CACHE_WAYS; i++) begin
                    order[s][i] <= way_idx_t'(i);
                end
            end
        end else if (touch) begin
            order[touch_set] <= next_order;
        end
    end

    assign victim = order[query_set][`CACHE_WAYS-1];

    touched_set_is_permutation: assert property (
        @(posedge clk_in) disable iff (reset)
        touch |=> is_permutation(order[$past(touch_set)])
    ) else $error("lru_tracker: set %0d lost a way", $past(touch_set));

endmodule

`default_nettype wire

//--- verilog/tag_lookup.sv
`default_nettype none

`include "cache_macros.svh"

module tag_lookup (
    input  logic [`ADDR_WIDTH-1:0]                  addr,
    input  logic [`CACHE_WAYS-1:0][`TAG_BITS-1:0]   tags,
    input  logic [`CACHE_WAYS-1:0]                  valids,
    output cache_pkg::lookup_t                      result
);
    import cache_pkg::*;

    addr_fields_t           fields;
    logic [`CACHE_WAYS-1:0] match;
    way_idx_t               hit_way;

    // Split the byte address into tag, index and offset.
    assign fields = addr_fields_t'(addr);

    // Every way of the set is compared at once.
    always_comb begin
        for (int w = 0; w < `CACHE_WAYS; w++) begin
            match[w] = valids[w] && (tags[w] == fields.tag);
        end
    end

    // Encode the matching way.
    always_comb begin
        hit_way = '0;
        for (int w = 0; w < `CACHE_WAYS; w++) begin
            if (match[w]) begin
                hit_way = way_idx_t'(w);
            end
        end
    end

    assign result = '{
        hit:    |match,
        way:    hit_way,
        fields: fields
    };

    // A line is only ever installed into one way of its set, so a second
    // match means the fill picked a way while the tag was still present.
    one_way_match: assert final ($isunknown(match) || $onehot0(match))
        else $error("tag_lookup: address %h matches more than one way", addr);

endmodule

`default_nettype wire

//--- verilog/cache_pkg.sv
`default_nettype none

`include "cache_macros.svh"

package cache_pkg;

    typedef logic [`WAY_BITS-1:0] way_idx_t;

    // Byte 0 of the line sits at offset 0.
    typedef logic [`LINE_BYTES-1:0][7:0] line_t;

    typedef struct packed {
        logic                   write;
        logic [`ADDR_WIDTH-1:0] addr;
        logic [7:0]             wdata;
    } cpu_req_t;

    typedef struct packed {
        logic [7:0] rdata;
        logic       hit;
    } cpu_resp_t;

    typedef struct packed {
        logic [`TAG_BITS-1:0]    tag;
        logic [`INDEX_BITS-1:0]  index;
        logic [`OFFSET_BITS-1:0] offset;
    } addr_fields_t;

    // A read ignores wdata and the offset bits of addr.
    typedef struct packed {
        logic                   write;
        logic [`ADDR_WIDTH-1:0] addr;
        logic [7:0]             wdata;
    } mem_req_t;

    typedef struct packed {
        logic         hit;
        way_idx_t     way;
        addr_fields_t fields;
    } lookup_t;

endpackage

`default_nettype wire

//--- include/cache_macros.svh
`ifndef CACHE_MACROS_SVH
`define CACHE_MACROS_SVH

// Cache geometry.
`define CACHE_WAYS  4
`define CACHE_SETS  16
`define LINE_BYTES  16
`define ADDR_WIDTH  12

// Field widths that follow from the geometry.
`define WAY_BITS    $clog2(`CACHE_WAYS)
`define OFFSET_BITS $clog2(`LINE_BYTES)
`define INDEX_BITS  $clog2(`CACHE_SETS)
`define TAG_BITS    (`ADDR_WIDTH - `INDEX_BITS - `OFFSET_BITS)

// Cycles from a line-read strobe to the fill strobe.
`define MEM_LATENCY 3

`endif
